// File: hw/car_pkg.sv
`default_nettype none

package car_pkg;

    ////////////////////
    // car modes

    typedef enum logic [4:0] {
        NONE    = 5'b00000,
        START   = 5'b00001,
        INTER   = 5'b00010,
        RUN     = 5'b00100,
        WARNING = 5'b01000,
        SEARCH  = 5'b10000
    } mode_t;

    ////////////////////
    // held command, one-hot

    typedef logic [7:0] cmd_t;

    localparam cmd_t CMD_NONE   = 8'b0000_0000;
    localparam cmd_t CMD_DANGER = 8'b1000_0000; // D
    localparam cmd_t CMD_INIT   = 8'b0100_0000; // i
    localparam cmd_t CMD_END    = 8'b0010_0000; // e
    localparam cmd_t CMD_STOP   = 8'b0001_0000; // s
    localparam cmd_t CMD_FWD    = 8'b0000_1000; // f
    localparam cmd_t CMD_LEFT   = 8'b0000_0100; // l
    localparam cmd_t CMD_RIGHT  = 8'b0000_0010; // r
    localparam cmd_t CMD_BACK   = 8'b0000_0001; // b

    // motion direction from the sensor
    typedef logic [4:0] dir_t;

    localparam dir_t DIR_FWD   = 5'b10000;
    localparam dir_t DIR_LEFT  = 5'b01000;
    localparam dir_t DIR_STOP  = 5'b00100;
    localparam dir_t DIR_RIGHT = 5'b00010;
    localparam dir_t DIR_BACK  = 5'b00001;

    ////////////////////
    // serial link

    localparam int BYTE_W       = 8;
    localparam int FRAME_BITS   = BYTE_W + 2;           // start + data + stop
    localparam int CLKS_PER_BIT = 16;
    localparam int HALF_BIT     = CLKS_PER_BIT / 2;
    localparam int BIT_CNT_W    = $clog2(CLKS_PER_BIT);

    // letters from the host
    localparam logic [BYTE_W-1:0] LTR_D = 8'h44;
    localparam logic [BYTE_W-1:0] LTR_I = 8'h69;
    localparam logic [BYTE_W-1:0] LTR_E = 8'h65;
    localparam logic [BYTE_W-1:0] LTR_S = 8'h73;
    localparam logic [BYTE_W-1:0] LTR_F = 8'h66;
    localparam logic [BYTE_W-1:0] LTR_L = 8'h6C;
    localparam logic [BYTE_W-1:0] LTR_R = 8'h72;
    localparam logic [BYTE_W-1:0] LTR_B = 8'h62;

    // letters back to the host
    localparam logic [BYTE_W-1:0] RPT_F = 8'h46;
    localparam logic [BYTE_W-1:0] RPT_L = 8'h4C;
    localparam logic [BYTE_W-1:0] RPT_R = 8'h52;
    localparam logic [BYTE_W-1:0] RPT_S = 8'h53;
    localparam logic [BYTE_W-1:0] RPT_B = 8'h42;
    localparam logic [BYTE_W-1:0] RPT_W = 8'h57;

    // seven segment, bit 6 = g .. bit 0 = a, active high
    localparam logic [6:0] SEG_PATTERNS [0:8] = '{
        7'h3F, 7'h06, 7'h5B, 7'h4F, 7'h66,
        7'h6D, 7'h7D, 7'h07, 7'h7F
    };

endpackage

`default_nettype wire

// File: hw/uart_rx.sv
`timescale 1ns/1ps
`default_nettype none

module uart_rx (
    input  wire logic                      clk,
    input  wire logic                      I_rst_n,
    input  wire logic                      rxd,
    output logic [car_pkg::BYTE_W-1:0]     rx_data,
    output logic                           rx_valid
);
    import car_pkg::*;

    logic                 rxd_meta;
    logic                 rxd_sync;
    logic                 busy;
    logic [BIT_CNT_W-1:0] clk_cnt;
    logic [3:0]           bit_idx;     // 0 start, 1..8 data, 9 stop
    logic [BYTE_W-1:0]    shift_reg;
    logic                 sample_now;

    // two flop synchronizer, idles high
    always_ff @(posedge clk) begin
        if (!I_rst_n) begin
            rxd_meta <= 1'b1;
            rxd_sync <= 1'b1;
        end else begin
            rxd_meta <= rxd;
            rxd_sync <= rxd_meta;
        end
    end

    // half a bit to reach the middle of start, then full bits
    assign sample_now = (bit_idx == 4'd0) ? (clk_cnt == BIT_CNT_W'(HALF_BIT - 1))
                                          : (clk_cnt == BIT_CNT_W'(CLKS_PER_BIT - 1));

    always_ff @(posedge clk) begin
        if (!I_rst_n) begin
            busy     <= 1'b0;
            clk_cnt  <= '0;
            bit_idx  <= '0;
            rx_valid <= 1'b0;
        end else begin
            rx_valid <= 1'b0;
            if (!busy) begin
                if (!rxd_sync) begin        // start edge
                    busy    <= 1'b1;
                    clk_cnt <= '0;
                    bit_idx <= '0;
                end
            end else if (sample_now) begin
                clk_cnt <= '0;
                if (bit_idx == 4'd0) begin
                    if (rxd_sync)
                        busy <= 1'b0;       // glitch, not a start bit
                    else
                        bit_idx <= 4'd1;
                end else if (bit_idx == 4'(FRAME_BITS - 1)) begin
                    busy     <= 1'b0;
                    rx_valid <= rxd_sync;   // bad stop bit drops the byte
                end else begin
                    bit_idx <= bit_idx + 4'd1;
                end
            end else begin
                clk_cnt <= clk_cnt + 1'b1;
            end
        end
    end

    // lsb first
    always_ff @(posedge clk) begin
        if (busy && sample_now && bit_idx != 4'd0 && bit_idx != 4'(FRAME_BITS - 1))
            shift_reg <= {rxd_sync, shift_reg[BYTE_W-1:1]};
    end

    assign rx_data = shift_reg;

endmodule

`default_nettype wire

// File: hw/uart_tx.sv
`timescale 1ns/1ps
`default_nettype none

module uart_tx (
    input  wire logic                        clk,
    input  wire logic                        I_rst_n,
    input  wire logic                        tx_send,
    input  wire logic [car_pkg::BYTE_W-1:0]  tx_data,
    output logic                             txd,
    output logic                             tx_idle
);
    import car_pkg::*;

    logic [FRAME_BITS-1:0] frame;      // bit 0 is on the line
    logic                  busy;
    logic [BIT_CNT_W-1:0]  clk_cnt;
    logic [3:0]            bit_cnt;

    always_ff @(posedge clk) begin
        if (!I_rst_n) begin
            frame   <= '1;              // line rests high
            busy    <= 1'b0;
            clk_cnt <= '0;
            bit_cnt <= '0;
        end else if (!busy) begin
            if (tx_send) begin
                frame   <= {1'b1, tx_data, 1'b0};
                busy    <= 1'b1;
                clk_cnt <= '0;
                bit_cnt <= '0;
            end
        end else if (clk_cnt == BIT_CNT_W'(CLKS_PER_BIT - 1)) begin
            clk_cnt <= '0;
            frame   <= {1'b1, frame[FRAME_BITS-1:1]};
            if (bit_cnt == 4'(FRAME_BITS - 1))
                busy <= 1'b0;           // stop bit done
            else
                bit_cnt <= bit_cnt + 4'd1;
        end else begin
            clk_cnt <= clk_cnt + 1'b1;
        end
    end

    assign txd     = frame[0];
    assign tx_idle = !busy;

endmodule

`default_nettype wire

// File: hw/cmd_decoder.sv
`timescale 1ns/1ps
`default_nettype none

module cmd_decoder (
    input  wire logic                        clk,
    input  wire logic                        I_rst_n,
    input  wire logic                        rx_valid,
    input  wire logic [car_pkg::BYTE_W-1:0]  rx_data,
    output car_pkg::cmd_t                    cmd
);
    import car_pkg::*;

    // last recognized letter stays in force
    always_ff @(posedge clk) begin
        if (!I_rst_n) begin
            cmd <= CMD_NONE;
        end else if (rx_valid) begin
            case (rx_data)
                LTR_D:   cmd <= CMD_DANGER;
                LTR_I:   cmd <= CMD_INIT;
                LTR_E:   cmd <= CMD_END;
                LTR_S:   cmd <= CMD_STOP;
                LTR_F:   cmd <= CMD_FWD;
                LTR_L:   cmd <= CMD_LEFT;
                LTR_R:   cmd <= CMD_RIGHT;
                LTR_B:   cmd <= CMD_BACK;
                default: cmd <= cmd;    // unknown byte
            endcase
        end
    end

endmodule

`default_nettype wire

// File: hw/drive_fsm.sv
`timescale 1ns/1ps
`default_nettype none

module drive_fsm (
    input  wire logic            clk,
    input  wire logic            I_rst_n,
    input  wire car_pkg::cmd_t   cmd,
    input  wire logic            go,
    input  wire logic            execute,
    output car_pkg::mode_t       mode,
    output logic                 running
);
    import car_pkg::*;

    logic barrier;
    logic goback;
    logic direction;
    logic stop;
    logic done;

    ////////////////////
    // condition flags, one edge behind cmd

    always_ff @(posedge clk) begin
        if (!I_rst_n) begin
            barrier   <= 1'b0;
            goback    <= 1'b0;
            direction <= 1'b0;
            stop      <= 1'b0;
            done      <= 1'b0;
        end else begin
            barrier   <= (cmd == CMD_DANGER);
            goback    <= (cmd == CMD_BACK);
            direction <= (cmd == CMD_FWD) || (cmd == CMD_LEFT) ||
                         (cmd == CMD_RIGHT) || (cmd == CMD_BACK);   // b steers too
            stop      <= (cmd == CMD_STOP);
            done      <= (cmd == CMD_END);
        end
    end

    ////////////////////
    // mode register

    always_ff @(posedge clk) begin
        if (!I_rst_n) begin
            mode <= NONE;
        end else begin
            case (mode)
                NONE:    mode <= START;
                START:   if (go) mode <= INTER;
                INTER: begin
                    if (barrier)
                        mode <= WARNING;
                    else if (direction)
                        mode <= RUN;
                end
                RUN: begin
                    if (barrier)
                        mode <= WARNING;
                    else if (stop && execute)
                        mode <= SEARCH;
                end
                WARNING: if (goback) mode <= INTER;
                SEARCH:  if (done) mode <= INTER;
                default: mode <= START;     // illegal code
            endcase
        end
    end

    // sensor runs while the car is active
    always_ff @(posedge clk) begin
        if (!I_rst_n)
            running <= 1'b0;
        else
            running <= (mode == RUN) || (mode == WARNING) || (mode == INTER);
    end

endmodule

`default_nettype wire

// File: hw/report_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

module report_ctrl (
    input  wire logic              clk,
    input  wire logic              I_rst_n,
    input  wire car_pkg::mode_t    mode,
    input  wire car_pkg::dir_t     run_dir,
    input  wire car_pkg::cmd_t     cmd,
    input  wire logic              tx_idle,
    output logic                   tx_send,
    output logic [car_pkg::BYTE_W-1:0] tx_data
);
    import car_pkg::*;

    // sent-records, 1 = armed
    // order: search, forward, back, stop, left, right
    logic [5:0]        armed;
    logic [5:0]        hit;            // one-hot report due this cycle
    logic [BYTE_W-1:0] letter;

    ////////////////////
    // pick the report that is due

    always_comb begin
        hit    = 6'b000000;
        letter = RPT_W;
        if (tx_idle && !tx_send) begin  // one byte in flight at a time
            case (mode)
                SEARCH: begin
                    if (cmd != CMD_INIT && armed[5]) begin
                        hit    = 6'b100000;
                        letter = RPT_W;
                    end
                end
                RUN, INTER: begin
                    case (run_dir)
                        DIR_FWD: if (cmd != CMD_FWD && armed[4]) begin
                            hit    = 6'b010000;
                            letter = RPT_F;
                        end
                        DIR_BACK: if (cmd != CMD_BACK && armed[3]) begin
                            hit    = 6'b001000;
                            letter = RPT_B;
                        end
                        DIR_STOP: if (cmd != CMD_STOP && armed[2]) begin
                            hit    = 6'b000100;
                            letter = RPT_S;
                        end
                        DIR_LEFT: if (cmd != CMD_LEFT && armed[1]) begin
                            hit    = 6'b000010;
                            letter = RPT_L;
                        end
                        DIR_RIGHT: if (cmd != CMD_RIGHT && armed[0]) begin
                            hit    = 6'b000001;
                            letter = RPT_R;
                        end
                        default: ;
                    endcase
                end
                WARNING: begin
                    // only backing off is reported here
                    if (run_dir == DIR_BACK && cmd != CMD_BACK && armed[3]) begin
                        hit    = 6'b001000;
                        letter = RPT_B;
                    end
                end
                default: ;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (!I_rst_n) begin
            armed   <= 6'b111111;
            tx_send <= 1'b0;
        end else begin
            tx_send <= |hit;
            if (|hit)
                armed <= ~hit;          // own record off, the rest back on
        end
    end

    always_ff @(posedge clk) begin
        if (|hit)
            tx_data <= letter;
    end

endmodule

`default_nettype wire

// File: hw/cmd_display.sv
`timescale 1ns/1ps
`default_nettype none

module cmd_display (
    input  wire logic            clk,
    input  wire logic            I_rst_n,
    input  wire car_pkg::cmd_t   cmd,
    output logic [6:0]           seg
);
    import car_pkg::*;

    logic [3:0] digit;

    always_ff @(posedge clk) begin
        if (!I_rst_n) begin
            digit <= 4'd0;
        end else begin
            case (cmd)
                CMD_DANGER: digit <= 4'd1;
                CMD_INIT:   digit <= 4'd2;
                CMD_END:    digit <= 4'd3;
                CMD_STOP:   digit <= 4'd4;
                CMD_FWD:    digit <= 4'd5;
                CMD_LEFT:   digit <= 4'd6;
                CMD_RIGHT:  digit <= 4'd7;
                CMD_BACK:   digit <= 4'd8;
                default:    digit <= 4'd0;  // no command yet
            endcase
        end
    end

    assign seg = SEG_PATTERNS[digit];

endmodule

`default_nettype wire

// File: hw/car_top.sv
`timescale 1ns/1ps
`default_nettype none

module car_top (
    input  wire logic            clk,
    input  wire logic            I_rst_n,
    input  wire logic            rxd,
    input  wire logic            go,
    input  wire logic            execute,
    input  wire car_pkg::dir_t   run_dir,       // from the three-axis sensor
    output logic                 txd,
    output logic                 running,
    output car_pkg::mode_t       showstate,
    output logic [6:0]           seg
);
    import car_pkg::*;

    logic [BYTE_W-1:0] rx_data;
    logic              rx_valid;
    cmd_t              cmd;
    mode_t             mode;
    logic [BYTE_W-1:0] tx_data;
    logic              tx_send;
    logic              tx_idle;

    ////////////////////
    // command path

    uart_rx i_uart_rx (
        .clk      (clk),
        .I_rst_n  (I_rst_n),
        .rxd      (rxd),
        .rx_data  (rx_data),
        .rx_valid (rx_valid)
    );

    cmd_decoder i_cmd_decoder (
        .clk      (clk),
        .I_rst_n  (I_rst_n),
        .rx_valid (rx_valid),
        .rx_data  (rx_data),
        .cmd      (cmd)
    );

    drive_fsm i_drive_fsm (
        .clk      (clk),
        .I_rst_n  (I_rst_n),
        .cmd      (cmd),
        .go       (go),
        .execute  (execute),
        .mode     (mode),
        .running  (running)
    );

    ////////////////////
    // report path

    report_ctrl i_report_ctrl (
        .clk      (clk),
        .I_rst_n  (I_rst_n),
        .mode     (mode),
        .run_dir  (run_dir),
        .cmd      (cmd),
        .tx_idle  (tx_idle),
        .tx_send  (tx_send),
        .tx_data  (tx_data)
    );

    uart_tx i_uart_tx (
        .clk      (clk),
        .I_rst_n  (I_rst_n),
        .tx_send  (tx_send),
        .tx_data  (tx_data),
        .txd      (txd),
        .tx_idle  (tx_idle)
    );

    cmd_display i_cmd_display (
        .clk      (clk),
        .I_rst_n  (I_rst_n),
        .cmd      (cmd),
        .seg      (seg)
    );

    assign showstate = mode;    // mode straight out for debug

endmodule

`default_nettype wire

// File: tests/car_sva.sv
`timescale 1ns/1ps
`default_nettype none

module car_sva (
    input wire logic            clk,
    input wire logic            I_rst_n,
    input wire car_pkg::mode_t  mode,
    input wire logic            running,
    input wire logic            tx_send,
    input wire logic            tx_idle
);
    import car_pkg::*;

    // transmitter takes a byte only while idle
    send_while_idle: assert property (@(posedge clk) disable iff (!I_rst_n)
        tx_send |-> tx_idle)
        else $error("tx_send high while uart_tx busy");

    mode_legal: assert property (@(posedge clk) disable iff (!I_rst_n)
        $onehot0(mode))
        else $error("mode is not one-hot");

    // running is registered from last cycle's mode
    running_follows_mode: assert property (@(posedge clk) disable iff (!I_rst_n)
        running == (($past(mode) == RUN) || ($past(mode) == WARNING) ||
                    ($past(mode) == INTER)))
        else $error("running disagrees with previous mode");

endmodule

bind car_top car_sva i_car_sva (
    .clk     (clk),
    .I_rst_n (I_rst_n),
    .mode    (mode),
    .running (running),
    .tx_send (tx_send),
    .tx_idle (tx_idle)
);

`default_nettype wire

// File: tests/car_tb.sv
`timescale 1ns/1ps
`default_nettype none

module car_tb;
    import car_pkg::*;

    localparam int FRAME_CYCLES   = FRAME_BITS * CLKS_PER_BIT;
    localparam int SETTLE         = 2 * CLKS_PER_BIT;  // rx decode plus seg register
    localparam int START_WAIT     = 4 * FRAME_CYCLES;
    localparam int MODE_WAIT      = 2 * FRAME_CYCLES;
    // about 30 frames of traffic and quiet windows plus generous margin
    localparam int TIMEOUT_CYCLES = 20000;

    logic       clk;
    logic       I_rst_n;
    logic       rxd;
    logic       go;
    logic       execute;
    dir_t       run_dir;
    logic       txd;
    logic       running;
    mode_t      showstate;
    logic [6:0] seg;

    string      test_name = "none";
    int         cycle_count;

    car_top i_dut (
        .clk       (clk),
        .I_rst_n   (I_rst_n),
        .rxd       (rxd),
        .go        (go),
        .execute   (execute),
        .run_dir   (run_dir),
        .txd       (txd),
        .running   (running),
        .showstate (showstate),
        .seg       (seg)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    ////////////////////
    // helpers

    task automatic stop_on_failure();
        $display("Test failed");
        $fatal(1, "stopping at first failure");
    endtask

    task automatic check(input string what, input logic [31:0] expected,
                         input logic [31:0] actual);
        if (expected !== actual) begin
            $display("** Error [%s] %s: expected %0h, actual %0h",
                     test_name, what, expected, actual);
            stop_on_failure();
        end
    endtask

    task automatic wait_cycles(input int n);
        repeat (n) @(negedge clk);
    endtask

    // 8N1 lsb first and returns with the stop bit on the line
    task automatic send_byte(input logic [7:0] data);
        int i;
        repeat (CLKS_PER_BIT) @(posedge clk);   // idle gap keeps the last stop full
        rxd <= 1'b0;
        repeat (CLKS_PER_BIT) @(posedge clk);
        for (i = 0; i < BYTE_W; i++) begin
            rxd <= data[i];
            repeat (CLKS_PER_BIT) @(posedge clk);
        end
        rxd <= 1'b1;
    endtask

    // line monitor sampling at mid-bit
    task automatic recv_byte(output logic [7:0] data);
        int waited;
        int i;
        waited = 0;
        data   = '0;
        @(negedge clk);
        while (txd !== 1'b0) begin
            waited++;
            if (waited > START_WAIT) begin
                $display("no start bit on txd within %0d cycles in %s", START_WAIT, test_name);
                stop_on_failure();
            end
            @(negedge clk);
        end
        repeat (HALF_BIT) @(negedge clk);
        check("start bit", 32'(1'b0), 32'(txd));
        for (i = 0; i < BYTE_W; i++) begin
            repeat (CLKS_PER_BIT) @(negedge clk);
            data[i] = txd;
        end
        repeat (CLKS_PER_BIT) @(negedge clk);
        check("stop bit", 32'(1'b1), 32'(txd));
    endtask

    task automatic expect_quiet(input int n);
        repeat (n) begin
            @(negedge clk);
            if (txd !== 1'b1) begin
                $display("unexpected byte started on txd in %s", test_name);
                stop_on_failure();
            end
        end
    endtask

    task automatic wait_mode(input mode_t target);
        int n;
        n = 0;
        @(negedge clk);
        while (showstate !== target) begin
            n++;
            if (n > MODE_WAIT) begin
                $display("mode %s never arrived in %s", target.name(), test_name);
                stop_on_failure();
            end
            @(negedge clk);
        end
    endtask

    task automatic wait_rx_valid();
        int n;
        n = 0;
        @(negedge clk);
        while (i_dut.rx_valid !== 1'b1) begin
            n++;
            if (n > 2 * FRAME_CYCLES) begin
                $display("receiver never flagged a byte in %s", test_name);
                stop_on_failure();
            end
            @(negedge clk);
        end
    endtask

    task automatic show_letter(input logic [7:0] letter, input logic [3:0] digit);
        send_byte(letter);
        wait_cycles(SETTLE);
        check($sformatf("seg for '%c'", letter), 32'(SEG_PATTERNS[digit]), 32'(seg));
    endtask

    ////////////////////
    // directed tests

    task automatic reset_state();
        test_name = "reset";
        wait_cycles(3);
        check("showstate", 32'(START), 32'(showstate));
        check("running", 32'(1'b0), 32'(running));
        check("txd idle", 32'(1'b1), 32'(txd));
        check("seg", 32'(SEG_PATTERNS[0]), 32'(seg));
    endtask

    task automatic display_digits();
        test_name = "display";
        show_letter(LTR_D, 4'd1);
        show_letter(LTR_I, 4'd2);
        show_letter(LTR_E, 4'd3);
        show_letter(LTR_S, 4'd4);
        show_letter(LTR_F, 4'd5);
        show_letter(LTR_L, 4'd6);
        show_letter(LTR_R, 4'd7);
        show_letter(LTR_B, 4'd8);
        show_letter(8'h78, 4'd8);               // 'x' is not a command
    endtask

    task automatic mode_walk();
        logic [7:0] got;
        test_name = "mode_path";
        send_byte(LTR_I);                       // i raises no flag so INTER holds
        wait_cycles(SETTLE);
        check("mode before go", 32'(START), 32'(showstate));
        @(posedge clk);
        go <= 1'b1;
        wait_mode(INTER);
        @(posedge clk);
        go <= 1'b0;
        send_byte(LTR_F);
        wait_mode(RUN);
        wait_cycles(1);
        check("running in RUN", 32'(1'b1), 32'(running));
        send_byte(LTR_D);
        wait_mode(WARNING);
        send_byte(LTR_B);
        wait_mode(INTER);                       // b is goback and a direction
        wait_mode(RUN);
        @(posedge clk);
        execute <= 1'b1;
        send_byte(LTR_S);
        wait_mode(SEARCH);
        wait_cycles(1);
        check("running in SEARCH", 32'(1'b0), 32'(running));
        recv_byte(got);                         // search entry report
        check("search letter", 32'(RPT_W), 32'(got));
        @(posedge clk);
        execute <= 1'b0;
        send_byte(LTR_E);
        wait_mode(INTER);
    endtask

    task automatic direction_reports();
        logic [7:0] got;
        test_name = "dir_reports";
        send_byte(LTR_F);
        wait_mode(RUN);
        @(posedge clk);
        run_dir <= DIR_LEFT;
        recv_byte(got);
        check("left letter", 32'(RPT_L), 32'(got));
        expect_quiet(3 * FRAME_CYCLES);         // sent once only
        @(posedge clk);
        run_dir <= DIR_RIGHT;
        recv_byte(got);
        check("right letter", 32'(RPT_R), 32'(got));
        @(posedge clk);
        run_dir <= DIR_LEFT;
        recv_byte(got);
        check("left letter again", 32'(RPT_L), 32'(got));
        @(posedge clk);
        run_dir <= '0;
    endtask

    task automatic search_report();
        logic [7:0] got;
        test_name = "search_report";
        @(posedge clk);
        execute <= 1'b1;
        send_byte(LTR_S);
        wait_mode(SEARCH);
        recv_byte(got);
        check("search letter", 32'(RPT_W), 32'(got));
        expect_quiet(3 * FRAME_CYCLES);
        @(posedge clk);
        execute <= 1'b0;
        send_byte(LTR_E);
        wait_mode(INTER);
        send_byte(LTR_F);
        wait_mode(RUN);
        // another report re-arms the search record
        @(posedge clk);
        run_dir <= DIR_RIGHT;
        recv_byte(got);
        check("right letter", 32'(RPT_R), 32'(got));
        @(posedge clk);
        run_dir <= '0;
        send_byte(LTR_S);
        wait_cycles(SETTLE);
        check("mode on s without execute", 32'(RUN), 32'(showstate));
        // execute lands in the cycle cmd turns to i while the stop flag is still set
        fork
            send_byte(LTR_I);
            begin
                wait_rx_valid();
                @(posedge clk);
                execute <= 1'b1;
            end
        join
        wait_mode(SEARCH);
        expect_quiet(3 * FRAME_CYCLES);
        @(posedge clk);
        execute <= 1'b0;
        send_byte(LTR_E);
        wait_mode(INTER);
    endtask

    task automatic warning_report();
        logic [7:0] got;
        test_name = "warning_report";
        send_byte(LTR_D);
        wait_mode(WARNING);
        @(posedge clk);
        run_dir <= DIR_FWD;
        expect_quiet(3 * FRAME_CYCLES);         // only back counts here
        @(posedge clk);
        run_dir <= DIR_BACK;
        recv_byte(got);
        check("back letter", 32'(RPT_B), 32'(got));
    endtask

    ////////////////////
    // main sequence

    initial begin
        I_rst_n <= 1'b0;
        rxd     <= 1'b1;
        go      <= 1'b0;
        execute <= 1'b0;
        run_dir <= '0;
        repeat (4) @(posedge clk);
        I_rst_n <= 1'b1;
        reset_state();
        display_digits();
        mode_walk();
        direction_reports();
        search_report();
        warning_report();
        $display("Test completed successfully");
        $finish;
    end

    // watchdog
    initial begin
        cycle_count = 0;
        forever begin
            @(posedge clk);
            cycle_count++;
            if (cycle_count >= TIMEOUT_CYCLES) begin
                $display("run passed %0d cycles without finishing", TIMEOUT_CYCLES);
                stop_on_failure();
            end
        end
    end

endmodule

`default_nettype wire

// File: sim.f
hw/car_pkg.sv
hw/uart_rx.sv
hw/uart_tx.sv
hw/cmd_decoder.sv
hw/drive_fsm.sv
hw/report_ctrl.sv
hw/cmd_display.sv
hw/car_top.sv
tests/car_sva.sv
tests/car_tb.sv

// File: run.sh
#!/bin/sh
# compile and run the car testbench with Verilator, then judge the log
rm -f sim.log
verilator --binary --timing --assert --top-module car_tb -f sim.f \
    && ./obj_dir/Vcar_tb > sim.log 2>&1
grep -q "Test completed successfully" sim.log && echo "PASS" || { echo "FAIL"; exit 1; }
